// File: icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define ICACHE_SETS        64
`define ICACHE_LINE_BITS   128
`define ICACHE_ADDR_BITS   32

// set index into the tag and data stores
`define ICACHE_INDEX_BITS  $clog2(`ICACHE_SETS)

// byte offset inside one line
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_LINE_BITS / 8)

// whatever is left of the address is tag
`define ICACHE_TAG_BITS    (`ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

`endif

// File: icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    typedef logic [`ICACHE_LINE_BITS-1:0]  line_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

    // request kinds, one bit each
    typedef enum logic [2:0] {
        OP_NONE      = 3'b000,
        OP_FETCH     = 3'b001,
        OP_FILL      = 3'b010,
        OP_SNOOP_INV = 3'b100
    } op_t;

    // pending means the miss went out and the fill has not come back
    typedef enum logic [1:0] {
        ST_INVALID = 2'd0,
        ST_PENDING = 2'd1,
        ST_SHARED  = 2'd2
    } way_state_t;

    typedef struct packed {
        way_state_t state;
        logic       locked;
        logic       referenced;
    } way_meta_t;

    // one-hot way select
    typedef logic [3:0] way_vec_t;

    // bit 2: upper pair used last, bit 1: way 3 newer than way 2,
    // bit 0: way 1 newer than way 0
    typedef logic [2:0] plru_t;

    // one looked-up request out of f2
    typedef struct packed {
        op_t                 op;
        index_t              index;
        tag_t                tag;
        way_meta_t [3:0]     metas;
        plru_t               plru;
        way_vec_t            hit;
        line_t [3:0]         lines;
    } f2_req_t;

    typedef struct packed {
        logic     hit;
        way_vec_t way;
        line_t    line;
        plru_t    plru_next;
    } hit_info_t;

    typedef struct packed {
        way_vec_t way;
        logic     all_locked;
    } victim_t;

    // write commands to the three stores
    typedef struct packed {
        logic      en;
        index_t    index;
        way_vec_t  way;
        tag_t      tag;
        way_meta_t meta;
    } tag_write_t;

    typedef struct packed {
        logic   en;
        index_t index;
        plru_t  plru;
    } plru_write_t;

    typedef struct packed {
        logic     en;
        index_t   index;
        way_vec_t way;
        line_t    line;
    } data_write_t;

endpackage

// File: hit_path.sv
module hit_path (
    input  icache_pkg::f2_req_t   req,
    output icache_pkg::hit_info_t hit_info
);
    import icache_pkg::*;

    line_t sel_line;
    plru_t plru_next;
    logic  any_hit;
    logic  upper_hit;

    assign any_hit   = |req.hit;
    assign upper_hit = req.hit[3] | req.hit[2];

    // the hit vector is one-hot or zero, so an and-or mux does it
    always_comb begin
        sel_line = '0;
        for (int w = 0; w < 4; w++) begin
            if (req.hit[w]) begin
                sel_line = sel_line | req.lines[w];
            end
        end
    end

    // point the tree at the way just used
    always_comb begin
        plru_next[2] = upper_hit;
        if (upper_hit) begin
            // only the upper pair bit moves
            plru_next[1] = req.hit[3];
            plru_next[0] = req.plru[0];
        end else begin
            plru_next[1] = req.plru[1];
            plru_next[0] = req.hit[1];
        end
    end

    // opcode is not looked at here, update_merge decides what to use
    always_comb begin
        hit_info.hit       = any_hit;
        hit_info.way       = req.hit;
        hit_info.line      = sel_line;
        hit_info.plru_next = plru_next;
    end

endmodule

// File: victim_select.sv
module victim_select (
    input  icache_pkg::f2_req_t req,
    output icache_pkg::victim_t victim
);
    import icache_pkg::*;

    way_vec_t   locked;
    way_vec_t   free_ways;
    way_vec_t   first_free;
    way_vec_t   plru_way;
    logic [1:0] lower_pick;
    logic [1:0] upper_pick;

    // older way of a pair if it is unlocked, else its partner,
    // else nothing when both are locked
    function automatic logic [1:0] pick_in_pair(
        input logic [1:0] lk,
        input logic       hi_newer
    );
        logic [1:0] older;
        logic [1:0] pick;

        older = hi_newer ? 2'b01 : 2'b10;
        if ((older & ~lk) != 2'b00) begin
            pick = older;
        end else begin
            pick = ~older & ~lk;
        end
        return pick;
    endfunction

    always_comb begin
        for (int w = 0; w < 4; w++) begin
            locked[w]    = req.metas[w].locked;
            free_ways[w] = (req.metas[w].state == ST_INVALID) && !req.metas[w].locked;
        end
    end

    // lowest free way wins, scan from the top so the last write sticks
    always_comb begin
        first_free = '0;
        for (int w = 3; w >= 0; w--) begin
            if (free_ways[w]) begin
                first_free    = '0;
                first_free[w] = 1'b1;
            end
        end
    end

    assign lower_pick = pick_in_pair(locked[1:0], req.plru[0]);
    assign upper_pick = pick_in_pair(locked[3:2], req.plru[1]);

    // tree walk, starting in the pair that was not used last
    always_comb begin
        if (req.plru[2]) begin
            if (lower_pick != 2'b00) begin
                plru_way = {2'b00, lower_pick};
            end else begin
                plru_way = {upper_pick, 2'b00};
            end
        end else begin
            if (upper_pick != 2'b00) begin
                plru_way = {upper_pick, 2'b00};
            end else begin
                plru_way = {2'b00, lower_pick};
            end
        end
    end

    // plru_way is zero when every way is locked
    always_comb begin
        victim.all_locked = &locked;
        if (free_ways != '0) begin
            victim.way = first_free;
        end else begin
            victim.way = plru_way;
        end
    end

endmodule

// File: update_merge.sv
module update_merge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icache_pkg::f2_req_t     req,
    input  icache_pkg::line_t       l2_line,
    input  icache_pkg::hit_info_t   hit_info,
    input  icache_pkg::victim_t     victim,
    output logic                    cache_hit,
    output icache_pkg::line_t       fetch_line,
    output logic                    stall,
    output icache_pkg::tag_write_t  tag_wr,
    output icache_pkg::plru_write_t plru_wr,
    output icache_pkg::data_write_t data_wr
);
    import icache_pkg::*;

    logic        is_fetch;
    logic        is_fill;
    logic        is_snoop;
    logic        fetch_hit;
    logic        fetch_miss;
    logic        stall_d;
    logic        alloc;
    logic        fill_ok;
    logic        snoop_ok;
    way_meta_t   hit_meta;
    way_meta_t   next_meta;
    way_vec_t    target_way;
    line_t       fetch_line_d;
    tag_write_t  tag_wr_d;
    plru_write_t plru_wr_d;
    data_write_t data_wr_d;

    // opcode decode
    assign is_fetch = (req.op == OP_FETCH);
    assign is_fill  = (req.op == OP_FILL);
    assign is_snoop = (req.op == OP_SNOOP_INV);

    assign fetch_hit  = is_fetch && hit_info.hit;
    assign fetch_miss = is_fetch && !hit_info.hit;
    assign stall_d    = fetch_miss && victim.all_locked;
    assign alloc      = fetch_miss && !victim.all_locked;

    // meta of the hit way, zero when nothing hit
    always_comb begin
        hit_meta = '0;
        for (int w = 0; w < 4; w++) begin
            if (hit_info.way[w]) begin
                hit_meta = hit_meta | req.metas[w];
            end
        end
    end

    // a fill only lands on a way still waiting for it
    assign fill_ok  = is_fill && hit_info.hit && (hit_meta.state == ST_PENDING);
    assign snoop_ok = is_snoop && hit_info.hit;

    assign target_way = alloc ? victim.way : hit_info.way;

    // next state of the target way
    always_comb begin
        next_meta = hit_meta;
        if (fetch_hit) begin
            next_meta.referenced = 1'b1;
        end else if (alloc) begin
            next_meta.state      = ST_PENDING;
            next_meta.locked     = 1'b0;
            next_meta.referenced = 1'b0;
        end else if (fill_ok) begin
            next_meta.state      = ST_SHARED;
            next_meta.referenced = 1'b0;
        end else if (snoop_ok) begin
            // lock bit survives the invalidate
            next_meta.state      = ST_INVALID;
            next_meta.referenced = 1'b0;
        end
    end

    assign fetch_line_d = fetch_hit ? hit_info.line : '0;

    always_comb begin
        tag_wr_d.en    = fetch_hit || alloc || fill_ok || snoop_ok;
        tag_wr_d.index = req.index;
        tag_wr_d.way   = target_way;
        tag_wr_d.tag   = req.tag;
        tag_wr_d.meta  = next_meta;

        plru_wr_d.en    = fetch_hit;
        plru_wr_d.index = req.index;
        plru_wr_d.plru  = hit_info.plru_next;

        data_wr_d.en    = fill_ok;
        data_wr_d.index = req.index;
        data_wr_d.way   = hit_info.way;
        data_wr_d.line  = l2_line;
    end

    // one cycle from f2 to the stores
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_hit  <= 1'b0;
            fetch_line <= '0;
            stall      <= 1'b0;
            tag_wr     <= '0;
            plru_wr    <= '0;
            data_wr    <= '0;
        end else begin
            cache_hit  <= fetch_hit;
            fetch_line <= fetch_line_d;
            stall      <= stall_d;
            tag_wr     <= tag_wr_d;
            plru_wr    <= plru_wr_d;
            data_wr    <= data_wr_d;
        end
    end

endmodule

// File: icache_update.sv
module icache_update (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icache_pkg::f2_req_t     req,
    input  icache_pkg::line_t       l2_line,
    output logic                    cache_hit,
    output icache_pkg::line_t       fetch_line,
    output logic                    stall,
    output icache_pkg::tag_write_t  tag_wr,
    output icache_pkg::plru_write_t plru_wr,
    output icache_pkg::data_write_t data_wr
);
    import icache_pkg::*;

    hit_info_t hit_info;
    victim_t   victim;

    // both lookups are combinational and run side by side
    hit_path i_hit_path (
        .req      (req),
        .hit_info (hit_info)
    );

    victim_select i_victim_select (
        .req    (req),
        .victim (victim)
    );

    update_merge i_update_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .l2_line    (l2_line),
        .hit_info   (hit_info),
        .victim     (victim),
        .cache_hit  (cache_hit),
        .fetch_line (fetch_line),
        .stall      (stall),
        .tag_wr     (tag_wr),
        .plru_wr    (plru_wr),
        .data_wr    (data_wr)
    );

endmodule

// File: tb_icache_update.sv
module tb_icache_update;
    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int NUM_ROWS     = 20;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_CYCLES   = NUM_ROWS + RESET_CYCLES + 10;

    // meta shorthands, {state, locked, referenced}
    localparam way_meta_t M_INV   = '{ST_INVALID, 1'b0, 1'b0};
    localparam way_meta_t M_INV_L = '{ST_INVALID, 1'b1, 1'b0};
    localparam way_meta_t M_PEND  = '{ST_PENDING, 1'b0, 1'b0};
    localparam way_meta_t M_SH    = '{ST_SHARED, 1'b0, 1'b0};
    localparam way_meta_t M_SH_R  = '{ST_SHARED, 1'b0, 1'b1};
    localparam way_meta_t M_SH_L  = '{ST_SHARED, 1'b1, 1'b0};
    localparam way_meta_t M_SH_LR = '{ST_SHARED, 1'b1, 1'b1};

    typedef struct packed {
        op_t             op;
        way_vec_t        hit;
        way_meta_t [3:0] metas;
        plru_t           plru;
        index_t          index;
    } stim_t;

    typedef struct packed {
        logic      hit;
        logic      stall;
        logic      tag_en;
        way_vec_t  way;
        way_meta_t meta;
        logic      plru_en;
        plru_t     plru;
        logic      data_en;
    } expect_t;

    typedef struct packed {
        stim_t   stim;
        expect_t exp;
    } row_t;

    // no output strobe at all
    localparam expect_t NO_EFFECT = '0;

    logic        clk;
    logic        rst_n;
    f2_req_t     req;
    line_t       l2_line;
    logic        cache_hit;
    line_t       fetch_line;
    logic        stall;
    tag_write_t  tag_wr;
    plru_write_t plru_wr;
    data_write_t data_wr;

    row_t        rows [NUM_ROWS];
    tag_t        sent_tag [NUM_ROWS];
    line_t       sent_lines [NUM_ROWS][4];
    line_t       sent_l2 [NUM_ROWS];
    int          n_rows;
    int          errors;
    int          checks;
    int          cycle_count;
    logic [15:0] lfsr_state;

    icache_update i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .l2_line    (l2_line),
        .cache_hit  (cache_hit),
        .fetch_line (fetch_line),
        .stall      (stall),
        .tag_wr     (tag_wr),
        .plru_wr    (plru_wr),
        .data_wr    (data_wr)
    );

    always #4 clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output line_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic stim_t make_stim(input op_t op, input way_vec_t hit,
                                        input way_meta_t [3:0] metas, input plru_t plru,
                                        input index_t index);
        stim_t s;

        s.op    = op;
        s.hit   = hit;
        s.metas = metas;
        s.plru  = plru;
        s.index = index;
        return s;
    endfunction

    function automatic expect_t make_expect(input logic hit, input logic stl,
                                            input logic tag_en, input way_vec_t way,
                                            input way_meta_t meta, input logic plru_en,
                                            input plru_t plru, input logic data_en);
        expect_t e;

        e.hit     = hit;
        e.stall   = stl;
        e.tag_en  = tag_en;
        e.way     = way;
        e.meta    = meta;
        e.plru_en = plru_en;
        e.plru    = plru;
        e.data_en = data_en;
        return e;
    endfunction

    task automatic add_row(input stim_t s, input expect_t e);
        rows[n_rows].stim = s;
        rows[n_rows].exp  = e;
        n_rows++;
    endtask

    // metas are listed way 3 down to way 0
    task automatic build_table();
        add_row(make_stim(OP_NONE, 4'b0000, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd0),
                NO_EFFECT);
        // fetch hits, one per way
        add_row(make_stim(OP_FETCH, 4'b0001, {M_SH, M_SH, M_SH, M_SH}, 3'b110, 6'd1),
                make_expect(1'b1, 1'b0, 1'b1, 4'b0001, M_SH_R, 1'b1, 3'b010, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0010, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd2),
                make_expect(1'b1, 1'b0, 1'b1, 4'b0010, M_SH_R, 1'b1, 3'b001, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0100, {M_SH, M_SH_R, M_SH, M_SH}, 3'b011, 6'd3),
                make_expect(1'b1, 1'b0, 1'b1, 4'b0100, M_SH_R, 1'b1, 3'b101, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b1000, {M_SH_L, M_SH, M_SH, M_SH}, 3'b001, 6'd4),
                make_expect(1'b1, 1'b0, 1'b1, 4'b1000, M_SH_LR, 1'b1, 3'b111, 1'b0));
        // misses that find a free invalid way
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH, M_INV, M_SH, M_INV}, 3'b000, 6'd5),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0001, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_INV, M_SH, M_SH, M_INV_L}, 3'b000, 6'd6),
                make_expect(1'b0, 1'b0, 1'b1, 4'b1000, M_PEND, 1'b0, 3'b000, 1'b0));
        // misses that walk the tree
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd7),
                make_expect(1'b0, 1'b0, 1'b1, 4'b1000, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH, M_SH, M_SH, M_SH}, 3'b111, 6'd8),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0001, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH, M_SH, M_SH, M_SH}, 3'b010, 6'd9),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0100, M_PEND, 1'b0, 3'b000, 1'b0));
        // locked ways push the choice to the partner or the other pair
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH_L, M_SH, M_SH, M_SH}, 3'b000, 6'd10),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0100, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH, M_SH, M_SH_L, M_SH_L}, 3'b100, 6'd11),
                make_expect(1'b0, 1'b0, 1'b1, 4'b1000, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_SH_L, M_SH_L, M_SH_L, M_SH}, 3'b000, 6'd12),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0001, M_PEND, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_FETCH, 4'b0000, {M_INV_L, M_SH_L, M_SH_L, M_SH_L}, 3'b000, 6'd13),
                make_expect(1'b0, 1'b1, 1'b0, 4'b0000, M_INV, 1'b0, 3'b000, 1'b0));
        // fills
        add_row(make_stim(OP_FILL, 4'b0100, {M_SH, M_PEND, M_SH, M_SH}, 3'b000, 6'd14),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0100, M_SH, 1'b0, 3'b000, 1'b1));
        add_row(make_stim(OP_FILL, 4'b0010, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd15),
                NO_EFFECT);
        // snoops
        add_row(make_stim(OP_SNOOP_INV, 4'b1000, {M_SH_LR, M_SH, M_SH, M_SH}, 3'b000, 6'd16),
                make_expect(1'b0, 1'b0, 1'b1, 4'b1000, M_INV_L, 1'b0, 3'b000, 1'b0));
        add_row(make_stim(OP_SNOOP_INV, 4'b0000, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd17),
                NO_EFFECT);
        add_row(make_stim(OP_SNOOP_INV, 4'b0001, {M_SH, M_SH, M_SH, M_SH_R}, 3'b000, 6'd18),
                make_expect(1'b0, 1'b0, 1'b1, 4'b0001, M_INV, 1'b0, 3'b000, 1'b0));
        // idle with a stale hit vector
        add_row(make_stim(OP_NONE, 4'b0001, {M_SH, M_SH, M_SH, M_SH}, 3'b000, 6'd19),
                NO_EFFECT);
    endtask

    task automatic drive_row(input int k);
        f2_req_t r;
        line_t   v;

        r       = '0;
        r.op    = rows[k].stim.op;
        r.index = rows[k].stim.index;
        r.metas = rows[k].stim.metas;
        r.plru  = rows[k].stim.plru;
        r.hit   = rows[k].stim.hit;
        take_bits($bits(tag_t), v);
        r.tag       = v[$bits(tag_t)-1:0];
        sent_tag[k] = r.tag;
        for (int w = 0; w < 4; w++) begin
            take_bits($bits(line_t), v);
            r.lines[w]       = v;
            sent_lines[k][w] = v;
        end
        take_bits($bits(line_t), v);
        sent_l2[k] = v;
        req       <= r;
        l2_line   <= v;
    endtask

    task automatic report_mismatch(input string name, input string where,
                                   input line_t exp_v, input line_t got_v);
        errors++;
        $display("error: %s at %s expected %0h got %0h", name, where, exp_v, got_v);
    endtask

    task automatic check_row(input int k, input string where);
        expect_t e;
        line_t   exp_line;

        e        = rows[k].exp;
        exp_line = '0;
        for (int w = 0; w < 4; w++) begin
            if (e.hit && rows[k].stim.hit[w]) begin
                exp_line = sent_lines[k][w];
            end
        end
        checks++;
        if (cache_hit !== e.hit)
            report_mismatch("cache_hit", where, e.hit, cache_hit);
        if (stall !== e.stall)
            report_mismatch("stall", where, e.stall, stall);
        if (fetch_line !== exp_line)
            report_mismatch("fetch_line", where, exp_line, fetch_line);
        if (tag_wr.en !== e.tag_en)
            report_mismatch("tag_wr.en", where, e.tag_en, tag_wr.en);
        if (e.tag_en) begin
            if (tag_wr.index !== rows[k].stim.index)
                report_mismatch("tag_wr.index", where, rows[k].stim.index, tag_wr.index);
            if (tag_wr.way !== e.way)
                report_mismatch("tag_wr.way", where, e.way, tag_wr.way);
            if (tag_wr.tag !== sent_tag[k])
                report_mismatch("tag_wr.tag", where, sent_tag[k], tag_wr.tag);
            if (tag_wr.meta !== e.meta)
                report_mismatch("tag_wr.meta", where, e.meta, tag_wr.meta);
        end
        if (plru_wr.en !== e.plru_en)
            report_mismatch("plru_wr.en", where, e.plru_en, plru_wr.en);
        if (e.plru_en) begin
            if (plru_wr.index !== rows[k].stim.index)
                report_mismatch("plru_wr.index", where, rows[k].stim.index, plru_wr.index);
            if (plru_wr.plru !== e.plru)
                report_mismatch("plru_wr.plru", where, e.plru, plru_wr.plru);
        end
        if (data_wr.en !== e.data_en)
            report_mismatch("data_wr.en", where, e.data_en, data_wr.en);
        if (e.data_en) begin
            if (data_wr.index !== rows[k].stim.index)
                report_mismatch("data_wr.index", where, rows[k].stim.index, data_wr.index);
            if (data_wr.way !== e.way)
                report_mismatch("data_wr.way", where, e.way, data_wr.way);
            if (data_wr.line !== sent_l2[k])
                report_mismatch("data_wr.line", where, sent_l2[k], data_wr.line);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles before all rows were checked",
                     cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        l2_line     = '0;
        lfsr_state  = 16'd15796;
        n_rows      = 0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        build_table();
        if (n_rows != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
            errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // row 0 is idle, its expectation is the reset state too
        @(negedge clk);
        check_row(0, "reset");

        // back to back, row k-1 comes out while row k goes in
        for (int k = 0; k <= NUM_ROWS; k++) begin
            @(posedge clk);
            if (k < NUM_ROWS) begin
                drive_row(k);
            end else begin
                req <= '0;
            end
            @(negedge clk);
            if (k > 0) begin
                check_row(k - 1, $sformatf("row %0d", k - 1));
            end
        end

        $display("checked %0d rows, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
icache_pkg.sv
hit_path.sv
victim_select.sv
update_merge.sv
icache_update.sv
tb_icache_update.sv

// File: Bender.yml
package:
  name: icache_update

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - hit_path.sv
      - victim_select.sv
      - update_merge.sv
      - icache_update.sv
  - target: test
    files:
      - tb_icache_update.sv
